// File: verification/sm_trace.txt
// Entries 0-31: program words. Then in_pins, in_shift_dir, push count,
// expected pushed words in order, expected final out_pins
E035 E04A A0C9 8000  // 0-3   SET X 0x15, SET Y 0x0A, MOV ISR ~X, PUSH
A0D2 8000 4008 4024  // 4-7   MOV ISR rev Y, PUSH, IN pins 8, IN X 4
4064 8000 4000 8000  // 8-11  IN null 4, PUSH, IN pins 32, PUSH
E022 A0C1 8000 004D  // 12-15 SET X 2, MOV ISR X, PUSH, JMP X-- 13
0032 E03F A0C1 8000  // 16-19 JMP !X 18, SET X 0x1F skipped, MOV ISR X, PUSH
0076 E027 00B9 E03B  // 20-23 JMP !Y 22 not taken, SET X 7, JMP X!=Y 25, skipped
2000 A0C1 8000 E013  // 24-27 no-op skipped, MOV ISR X, PUSH, SET pins 0x13
E00C 001D 001E 001F  // 28-31 SET pins 0x0C, jump to self, unused
12345678             // in_pins
00000000             // in_shift_dir, left
00000009             // push count
FFFFFFEA             // ~X
50000000             // rev Y
00007850             // 0x78, then 4 bits of X, then 4 zero bits
12345678             // full 32-bit IN from pins
00000002             // loop pass with X=2
00000001             // loop pass with X=1
00000000             // loop pass with X=0
00000000             // X zero branch taken
00000007             // X != Y branch taken
0000000C             // final out_pins

// File: flist.f
source/sm_pkg.sv
source/sm_scratch.sv
source/sm_shift_in.sv
source/sm_control.sv
source/sm_machine.sv
verification/sm_machine_checker.sv
verification/sm_machine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module sm_machine_tb -Mdir obj_dir \
  -f flist.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vsm_machine_tb > sim.log 2>&1
cat sim.log
grep -F -q "*** TEST PASSED ***" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verification/sm_machine_tb.sv
/* Runs the program held in the trace and checks every pushed word and the final out_pins.
   Acknowledge delays are random but repeatable, from a fixed LFSR seed. */
`timescale 1ns/10ps

module sm_machine_tb;

  localparam int TRACE_DEPTH   = 64;
  localparam int PROG_WORDS    = 32;
  localparam int PINS_IDX      = 32;
  localparam int DIR_IDX       = 33;
  localparam int COUNT_IDX     = 34;
  localparam int PUSH_BASE_IDX = 35; // Expected words followed by final out_pins
  localparam int MAX_ACK_DELAY = 7;

  logic                       clk;
  logic                       reset;
  logic [sm_pkg::INSTR_W-1:0] instr;
  logic [sm_pkg::DATA_W-1:0]  in_pins;
  logic                       in_shift_dir;
  logic                       push_ack;
  logic [sm_pkg::PC_W-1:0]    pc;
  logic [sm_pkg::DATA_W-1:0]  out_pins;
  logic                       push_req;
  logic [sm_pkg::DATA_W-1:0]  push_data;

  logic [31:0] trace [TRACE_DEPTH];
  logic [31:0] lfsr;
  int          push_total;
  int          pushes_seen;

  sm_machine sm_machine_i (
    .clk          (clk),
    .reset        (reset),
    .instr        (instr),
    .in_pins      (in_pins),
    .in_shift_dir (in_shift_dir),
    .push_ack     (push_ack),
    .pc           (pc),
    .out_pins     (out_pins),
    .push_req     (push_req),
    .push_data    (push_data)
  );

  bind sm_machine sm_machine_checker checker_i (
    .clk         (clk),
    .reset       (reset),
    .push_req    (push_req),
    .push_ack    (push_ack),
    .push_data   (push_data),
    .shift_count (shift_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
      stop_run();
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    stop_run();
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_delay(output int delay);
    delay = 0;
    for (int i = 0; i < 3; i++) begin
      lfsr  = lfsr_step(lfsr);
      delay = (delay << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic logic is_self_jump(input logic [15:0] word, input logic [4:0] addr);
    return (word[15:13] == sm_pkg::OP_JMP) && (word[7:5] == sm_pkg::COND_ALWAYS)
           && (word[4:0] == addr);
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // One full four-phase exchange with a random wait before each ack edge
  task automatic acknowledge_push();
    int delay;
    draw_delay(delay);
    wait_cycles(delay);
    push_ack = 1'b1;
    while (push_req !== 1'b0) begin
      wait_cycles(1);
    end
    draw_delay(delay);
    wait_cycles(delay);
    push_ack    = 1'b0;
    pushes_seen = pushes_seen + 1;
  endtask

  task automatic answer_pushes();
    logic [sm_pkg::PC_W-1:0] push_pc;
    logic [sm_pkg::PC_W-1:0] next_pc;
    forever begin
      wait_cycles(1);
      if (push_req === 1'b1) begin
        if (pushes_seen >= push_total) begin
          report_error("DUT pushed more words than the trace expects");
        end else begin
          push_pc = pc;
          next_pc = push_pc + 1'b1; // Wraps 31 to 0
          check_value("push_data", push_data, trace[PUSH_BASE_IDX + pushes_seen]);
          check_value("push opcode at pc", trace[push_pc][15:13], sm_pkg::OP_PUSH);
          acknowledge_push();
          wait_cycles(1);
          check_value("pc", pc, next_pc); // Advances only once ack has dropped
        end
      end
    end
  endtask

  initial answer_pushes();

  initial begin
    int limit;
    wait (reset === 1'b0);
    limit = 200 * PROG_WORDS + 40 * push_total * MAX_ACK_DELAY;
    repeat (limit) @(posedge clk);
    report_error($sformatf("program did not finish within %0d cycles", limit));
  end

  initial begin
    reset        = 1'b1;
    push_ack     = 1'b0;
    instr        = '0;
    in_pins      = '0;
    in_shift_dir = 1'b0;
    lfsr         = 32'h29cd_0987;
    pushes_seen  = 0;
    $readmemh("verification/sm_trace.txt", trace);
    push_total   = int'(trace[COUNT_IDX]);
    in_pins      = trace[PINS_IDX];
    in_shift_dir = trace[DIR_IDX][0];
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
    while (pushes_seen < push_total) @(negedge clk);
    while (!is_self_jump(instr, pc)) @(negedge clk);
    check_value("out_pins", out_pins, trace[PUSH_BASE_IDX + push_total]);
    if (sm_machine_i.checker_i.assert_failed) begin
      report_error("a push handshake assertion failed during the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  // Program memory read once pc has settled after the edge
  always @(posedge clk) begin
    #1 instr = trace[pc][sm_pkg::INSTR_W-1:0];
  end

endmodule

// File: verification/sm_machine_checker.sv
/* Push handshake assertions, bound into sm_machine. Assumes the synchronous reset. */
`timescale 1ns/10ps

module sm_machine_checker (
  input logic                      clk,
  input logic                      reset,
  input logic                      push_req,
  input logic                      push_ack,
  input logic [sm_pkg::DATA_W-1:0] push_data,
  input logic [sm_pkg::CNT_W-1:0]  shift_count
);

  logic assert_failed = 1'b0;

  // Request is cleared one edge into reset
  req_low_in_reset: assert property (@(posedge clk) reset |=> !push_req)
    else begin
      assert_failed = 1'b1;
      $error("push_req high during reset");
    end

  data_stable_during_req: assert property (
    @(posedge clk) disable iff (reset)
    push_req |=> (!push_req || $stable(push_data))
  ) else begin
    assert_failed = 1'b1;
    $error("push_data changed while push_req was high");
  end

  // Next request waits for the previous ack to fall
  no_req_rise_with_ack: assert property (
    @(posedge clk) disable iff (reset)
    $rose(push_req) |-> !$past(push_ack)
  ) else begin
    assert_failed = 1'b1;
    $error("push_req rose while push_ack was high");
  end

  // A push clears the ISR, so its bit count restarts at zero
  count_cleared_on_push: assert property (
    @(posedge clk) disable iff (reset)
    $rose(push_req) |-> (shift_count == '0)
  ) else begin
    assert_failed = 1'b1;
    $error("shift_count not cleared by the push");
  end

endmodule

// File: source/sm_machine.sv
/* Top of the reduced state machine. Program memory lives outside; pc goes out,
   instr comes back in the same cycle. */
`timescale 1ns/10ps

module sm_machine #(
  parameter int unsigned SET_BASE  = 0,
  parameter int unsigned SET_COUNT = 5
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [sm_pkg::INSTR_W-1:0] instr,
  input  logic [sm_pkg::DATA_W-1:0]  in_pins,
  input  logic                       in_shift_dir, // 0 left, 1 right
  input  logic                       push_ack,
  output logic [sm_pkg::PC_W-1:0]    pc,
  output logic [sm_pkg::DATA_W-1:0]  out_pins,
  output logic                       push_req,
  output logic [sm_pkg::DATA_W-1:0]  push_data
);

  logic [sm_pkg::DATA_W-1:0] x;
  logic [sm_pkg::DATA_W-1:0] y;
  logic [sm_pkg::DATA_W-1:0] isr;
  logic [sm_pkg::DATA_W-1:0] new_val;
  logic [sm_pkg::OP2_W-1:0]  shift_bits;
  logic [sm_pkg::CNT_W-1:0]  shift_count; // Visible to the checker
  logic                      set_x;
  logic                      set_y;
  logic                      dec_x;
  logic                      dec_y;
  logic                      isr_load;
  logic                      isr_shift;

  sm_scratch scratch_i (
    .clk     (clk),
    .reset   (reset),
    .set_x   (set_x),
    .set_y   (set_y),
    .dec_x   (dec_x),
    .dec_y   (dec_y),
    .new_val (new_val),
    .x       (x),
    .y       (y)
  );

  sm_shift_in shift_in_i (
    .clk         (clk),
    .reset       (reset),
    .dir         (in_shift_dir),
    .isr_load    (isr_load),
    .isr_shift   (isr_shift),
    .shift_bits  (shift_bits),
    .new_val     (new_val),
    .isr         (isr),
    .shift_count (shift_count)
  );

  sm_control #(
    .SET_BASE  (SET_BASE),
    .SET_COUNT (SET_COUNT)
  ) control_i (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .in_pins    (in_pins),
    .x          (x),
    .y          (y),
    .isr        (isr),
    .push_ack   (push_ack),
    .pc         (pc),
    .out_pins   (out_pins),
    .push_req   (push_req),
    .push_data  (push_data),
    .set_x      (set_x),
    .set_y      (set_y),
    .dec_x      (dec_x),
    .dec_y      (dec_y),
    .isr_load   (isr_load),
    .isr_shift  (isr_shift),
    .shift_bits (shift_bits),
    .new_val    (new_val)
  );

endmodule

// File: source/sm_control.sv
/* Decoder, value select, PC and the push handshake. One instruction per cycle,
   none while a push is pending. SET_BASE + SET_COUNT must not exceed 32. */
`timescale 1ns/10ps

module sm_control #(
  parameter int unsigned SET_BASE  = 0,
  parameter int unsigned SET_COUNT = 5
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [sm_pkg::INSTR_W-1:0] instr,
  input  logic [sm_pkg::DATA_W-1:0]  in_pins,
  input  logic [sm_pkg::DATA_W-1:0]  x,
  input  logic [sm_pkg::DATA_W-1:0]  y,
  input  logic [sm_pkg::DATA_W-1:0]  isr,
  input  logic                       push_ack,
  output logic [sm_pkg::PC_W-1:0]    pc,
  output logic [sm_pkg::DATA_W-1:0]  out_pins,
  output logic                       push_req,
  output logic [sm_pkg::DATA_W-1:0]  push_data,
  output logic                       set_x,
  output logic                       set_y,
  output logic                       dec_x,
  output logic                       dec_y,
  output logic                       isr_load,
  output logic                       isr_shift,
  output logic [sm_pkg::OP2_W-1:0]   shift_bits,
  output logic [sm_pkg::DATA_W-1:0]  new_val
);

  sm_pkg::opcode_e           op;
  sm_pkg::src_e              dest;      // Operand 1 as destination
  sm_pkg::src_e              src_sel;
  sm_pkg::cond_e             cond;
  sm_pkg::bitop_e            bitop;
  sm_pkg::push_state_e       state;
  logic [2:0]                op1;
  logic [sm_pkg::OP2_W-1:0]  op2;
  logic [sm_pkg::DATA_W-1:0] src_val;
  logic [sm_pkg::DATA_W-1:0] mov_val;
  logic                      src_ok;    // Source code is defined
  logic                      take_jump;
  logic                      set_pins;
  logic                      push_go;

  assign op    = sm_pkg::opcode_e'(instr[sm_pkg::OP_HI:sm_pkg::OP_LO]);
  assign op1   = instr[sm_pkg::OP1_HI:sm_pkg::OP1_LO];
  assign op2   = instr[sm_pkg::OP2_W-1:0];
  assign dest  = sm_pkg::src_e'(op1);
  assign cond  = sm_pkg::cond_e'(op1);
  assign bitop = sm_pkg::bitop_e'(op2[4:3]);
  assign shift_bits = op2;

  // MOV takes its source from operand 2, IN from operand 1
  always_comb begin
    src_sel = (op == sm_pkg::OP_MOV) ? sm_pkg::src_e'(op2[2:0]) : dest;
    src_ok  = 1'b1;
    case (src_sel)
      sm_pkg::SRC_PINS: src_val = in_pins;
      sm_pkg::SRC_X:    src_val = x;
      sm_pkg::SRC_Y:    src_val = y;
      sm_pkg::SRC_NULL: src_val = '0;
      sm_pkg::SRC_ISR:  src_val = isr;
      default: begin
        src_val = '0;
        src_ok  = 1'b0;
      end
    endcase
    case (bitop)
      sm_pkg::BIT_INV: mov_val = ~src_val;
      sm_pkg::BIT_REV: mov_val = sm_pkg::bit_reverse(src_val);
      default:         mov_val = src_val; // Reserved acts as none
    endcase
  end

  always_comb begin
    set_x     = 1'b0;
    set_y     = 1'b0;
    dec_x     = 1'b0;
    dec_y     = 1'b0;
    isr_load  = 1'b0;
    isr_shift = 1'b0;
    set_pins  = 1'b0;
    push_go   = 1'b0;
    take_jump = 1'b0;
    new_val   = '0;
    if (state == sm_pkg::PUSH_IDLE) begin
      case (op)
        sm_pkg::OP_JMP: begin
          case (cond)
            sm_pkg::COND_ALWAYS: take_jump = 1'b1;
            sm_pkg::COND_X_ZERO: take_jump = (x == '0);
            sm_pkg::COND_X_DEC: begin
              take_jump = (x != '0);
              dec_x     = (x != '0);
            end
            sm_pkg::COND_Y_ZERO: take_jump = (y == '0);
            sm_pkg::COND_Y_DEC: begin
              take_jump = (y != '0);
              dec_y     = (y != '0);
            end
            sm_pkg::COND_X_NE_Y: take_jump = (x != y);
            default:             take_jump = 1'b0;
          endcase
        end
        sm_pkg::OP_IN: begin
          isr_shift = src_ok;
          new_val   = src_val;
        end
        sm_pkg::OP_PUSH: begin
          if (!op1[2]) begin // Bit 2 set is PULL
            push_go  = 1'b1;
            isr_load = 1'b1; // Clear ISR with zero new_val
          end
        end
        sm_pkg::OP_MOV: begin
          new_val = mov_val;
          case (dest)
            sm_pkg::SRC_X:   set_x    = src_ok;
            sm_pkg::SRC_Y:   set_y    = src_ok;
            sm_pkg::SRC_ISR: isr_load = src_ok;
            default: ;
          endcase
        end
        sm_pkg::OP_SET: begin
          new_val = sm_pkg::DATA_W'(op2);
          case (dest)
            sm_pkg::SRC_PINS: set_pins = 1'b1;
            sm_pkg::SRC_X:    set_x    = 1'b1;
            sm_pkg::SRC_Y:    set_y    = 1'b1;
            default: ;
          endcase
        end
        default: ; // WAIT, OUT, IRQ are no-ops
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      case (state)
        sm_pkg::PUSH_IDLE: begin
          if (take_jump) begin
            pc <= op2;
          end else if (!push_go) begin
            pc <= pc + 1'b1; // Wraps 31 to 0
          end
        end
        sm_pkg::PUSH_RELEASE: if (!push_ack) pc <= pc + 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= sm_pkg::PUSH_IDLE;
      push_req  <= 1'b0;
      push_data <= '0;
    end else begin
      case (state)
        sm_pkg::PUSH_IDLE: begin
          if (push_go) begin
            push_data <= isr;
            push_req  <= 1'b1;
            state     <= sm_pkg::PUSH_REQ;
          end
        end
        sm_pkg::PUSH_REQ: begin
          if (push_ack) begin
            push_req <= 1'b0;
            state    <= sm_pkg::PUSH_RELEASE;
          end
        end
        sm_pkg::PUSH_RELEASE: if (!push_ack) state <= sm_pkg::PUSH_IDLE;
        default: begin
          push_req <= 1'b0;
          state    <= sm_pkg::PUSH_IDLE;
        end
      endcase
    end
  end

  // SET pins touches only its own field
  always_ff @(posedge clk) begin
    if (reset) begin
      out_pins <= '0;
    end else if (set_pins) begin
      for (int unsigned i = 0; i < sm_pkg::OP2_W; i++) begin
        if (i < SET_COUNT) out_pins[SET_BASE+i] <= op2[i];
      end
    end
  end

endmodule

// File: source/sm_shift_in.sv
/* Input shift register. A shift_bits of 0 shifts in 32 bits.
   dir=0 shifts left with bits entering at the bottom, dir=1 shifts right. */
`timescale 1ns/10ps

module sm_shift_in (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      dir,
  input  logic                      isr_load,
  input  logic                      isr_shift,
  input  logic [sm_pkg::OP2_W-1:0]  shift_bits,
  input  logic [sm_pkg::DATA_W-1:0] new_val,
  output logic [sm_pkg::DATA_W-1:0] isr,
  output logic [sm_pkg::CNT_W-1:0]  shift_count
);

  logic [sm_pkg::CNT_W-1:0]  n;        // Bits to shift, 1 to 32
  logic [sm_pkg::DATA_W-1:0] in_bits;
  logic [sm_pkg::DATA_W-1:0] shifted;
  logic [sm_pkg::CNT_W:0]    sum;      // One extra bit for up to 64

  always_comb begin
    n = (shift_bits == '0) ? sm_pkg::CNT_W'(sm_pkg::DATA_W) : sm_pkg::CNT_W'(shift_bits);
    in_bits = new_val & ~({sm_pkg::DATA_W{1'b1}} << n);
    if (dir) begin
      shifted = (isr >> n) | (in_bits << (sm_pkg::CNT_W'(sm_pkg::DATA_W) - n));
    end else begin
      shifted = (isr << n) | in_bits;
    end
    sum = {1'b0, shift_count} + {1'b0, n};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      isr         <= '0;
      shift_count <= '0;
    end else if (isr_load) begin
      isr         <= new_val;
      shift_count <= '0;
    end else if (isr_shift) begin
      isr <= shifted;
      if (sum > (sm_pkg::CNT_W + 1)'(sm_pkg::DATA_W)) begin
        shift_count <= sm_pkg::CNT_W'(sm_pkg::DATA_W); // Saturate at 32
      end else begin
        shift_count <= sum[sm_pkg::CNT_W-1:0];
      end
    end
  end

endmodule

// File: source/sm_scratch.sv
/* X and Y scratch words. Load wins over decrement if both are asserted. */
`timescale 1ns/10ps

module sm_scratch (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      set_x,
  input  logic                      set_y,
  input  logic                      dec_x,
  input  logic                      dec_y,
  input  logic [sm_pkg::DATA_W-1:0] new_val,
  output logic [sm_pkg::DATA_W-1:0] x,
  output logic [sm_pkg::DATA_W-1:0] y
);

  // Index 0 is X, index 1 is Y
  logic [sm_pkg::DATA_W-1:0] word [2];
  logic [1:0]                set_w;
  logic [1:0]                dec_w;

  assign set_w = {set_y, set_x};
  assign dec_w = {dec_y, dec_x};

  always_ff @(posedge clk) begin
    if (reset) begin
      word[0] <= '0;
      word[1] <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (set_w[i]) begin
          word[i] <= new_val;
        end else if (dec_w[i]) begin
          word[i] <= word[i] - 1'b1; // Wraps below zero
        end
      end
    end
  end

  assign x = word[0];
  assign y = word[1];

endmodule

// File: source/sm_pkg.sv
/* Shared widths, encodings and helpers for the state machine.
   Instruction fields follow the 16-bit format; bits 12:8 carry nothing here. */
package sm_pkg;

  localparam int DATA_W  = 32; // Datapath and pin width
  localparam int PC_W    = 5;
  localparam int INSTR_W = 16;
  localparam int CNT_W   = 6;  // Holds 0 to 32

  // Instruction field positions
  localparam int OP_HI  = 15;
  localparam int OP_LO  = 13;
  localparam int OP1_HI = 7;
  localparam int OP1_LO = 5;
  localparam int OP2_W  = 5;   // Operand 2 sits in bits 4:0

  typedef enum logic [2:0] {
    OP_JMP  = 3'd0,
    OP_WAIT = 3'd1,
    OP_IN   = 3'd2,
    OP_OUT  = 3'd3,
    OP_PUSH = 3'd4,
    OP_MOV  = 3'd5,
    OP_IRQ  = 3'd6,
    OP_SET  = 3'd7
  } opcode_e;

  // Source code, reused as destination code
  typedef enum logic [2:0] {
    SRC_PINS = 3'd0,
    SRC_X    = 3'd1,
    SRC_Y    = 3'd2,
    SRC_NULL = 3'd3,
    SRC_ISR  = 3'd6
  } src_e;

  typedef enum logic [2:0] {
    COND_ALWAYS = 3'd0,
    COND_X_ZERO = 3'd1,
    COND_X_DEC  = 3'd2, // X nonzero, then X--
    COND_Y_ZERO = 3'd3,
    COND_Y_DEC  = 3'd4, // Y nonzero, then Y--
    COND_X_NE_Y = 3'd5,
    COND_RES6   = 3'd6,
    COND_RES7   = 3'd7
  } cond_e;

  typedef enum logic [1:0] {BIT_NONE, BIT_INV, BIT_REV, BIT_RES} bitop_e;

  typedef enum logic [1:0] {PUSH_IDLE, PUSH_REQ, PUSH_RELEASE} push_state_e;

  function automatic logic [DATA_W-1:0] bit_reverse(input logic [DATA_W-1:0] v);
    logic [DATA_W-1:0] r;
    for (int i = 0; i < DATA_W; i++) begin
      r[i] = v[DATA_W-1-i];
    end
    return r;
  endfunction

endpackage
